/* src/hart_pkg.sv */
package hart_pkg;

  localparam int XLEN = 32;  // data and address width

  // major opcodes of the rv32i base set that this hart executes
  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_op_e;

  // wishbone classic master request
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic            we;
    logic [XLEN-1:0] adr;  // always word aligned
    logic [XLEN-1:0] dat;
    logic [3:0]      sel;  // one bit per byte lane
  } wb_req_t;

  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat;  // read data that is valid on the ack cycle
  } wb_rsp_t;

  typedef struct packed {
    opcode_e         opcode;
    logic [2:0]      funct3;
    alu_op_e         alu_op;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [XLEN-1:0] imm;
    logic            uses_imm;   // alu operand b comes from imm
    logic            writes_rd;
    logic            is_halt;    // ebreak
  } decoded_t;

  typedef struct packed {
    logic            valid;
    logic            halt;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] inst;
    logic [4:0]      rd_waddr;  // zero when nothing is written
    logic [XLEN-1:0] rd_wdata;
  } retire_t;

endpackage

/* src/fetch_unit.sv */
`timescale 1ns/1ns
module fetch_unit #(
  parameter logic [hart_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000
) (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_take,         // core consumes the buffered word
  input  logic                      i_redirect,
  input  logic [hart_pkg::XLEN-1:0] i_redirect_pc,
  output logic                      o_inst_valid,
  output logic [hart_pkg::XLEN-1:0] o_inst,
  output logic [hart_pkg::XLEN-1:0] o_inst_pc,
  output hart_pkg::wb_req_t         o_bus,
  input  hart_pkg::wb_rsp_t         i_bus
);

  logic [hart_pkg::XLEN-1:0] pc_q;        // next address to fetch
  logic [hart_pkg::XLEN-1:0] adr_q;       // address of the open read, stable until ack
  logic                      req_q;       // read cycle open
  logic                      drop_q;      // the open read went stale after a redirect
  logic                      buf_valid_q;
  logic [hart_pkg::XLEN-1:0] buf_word_q;
  logic [hart_pkg::XLEN-1:0] buf_pc_q;
  logic                      start;
  logic                      ack;

  // one word in flight or buffered, never both
  assign start = !req_q && !buf_valid_q && !i_redirect;
  assign ack   = req_q && i_bus.ack;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc_q        <= RESET_ADDR;
      req_q       <= 1'b0;
      drop_q      <= 1'b0;
      buf_valid_q <= 1'b0;
    end else begin
      if (start) begin
        req_q <= 1'b1;
        pc_q  <= pc_q + 32'd4;  // sequential prefetch
      end
      if (ack) begin
        req_q  <= 1'b0;
        drop_q <= 1'b0;
        if (!drop_q && !i_redirect) buf_valid_q <= 1'b1;  // stale data never reaches the buffer
      end
      if (i_take) buf_valid_q <= 1'b0;
      if (i_redirect) begin
        pc_q        <= i_redirect_pc;
        buf_valid_q <= 1'b0;
        if (req_q && !i_bus.ack) drop_q <= 1'b1;  // let the cycle finish and throw the word away
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (start) adr_q <= pc_q;
    if (ack) begin
      buf_word_q <= i_bus.dat;
      buf_pc_q   <= adr_q;
    end
  end

  always_comb begin
    o_bus     = '0;
    o_bus.cyc = req_q;
    o_bus.stb = req_q;
    o_bus.adr = adr_q;
    o_bus.sel = 4'b1111;  // instruction reads are whole words
  end

  assign o_inst_valid = buf_valid_q;
  assign o_inst       = buf_word_q;
  assign o_inst_pc    = buf_pc_q;

endmodule

/* src/bus_arbiter.sv */
`timescale 1ns/1ns
module bus_arbiter (
  input  logic              i_clk,
  input  logic              i_rst,
  input  hart_pkg::wb_req_t i_fetch_req,
  output hart_pkg::wb_rsp_t o_fetch_rsp,
  input  hart_pkg::wb_req_t i_lsu_req,
  output hart_pkg::wb_rsp_t o_lsu_rsp,
  output hart_pkg::wb_req_t o_wb,
  input  hart_pkg::wb_rsp_t i_wb
);

  logic busy_q;     // a cycle is open on the shared port
  logic lsu_own_q;  // owner of the open cycle

  // the owner only changes between cycles so the slave never sees a switch mid cycle
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy_q    <= 1'b0;
      lsu_own_q <= 1'b0;
    end else if (!busy_q) begin
      if (i_lsu_req.cyc) begin  // data accesses first
        busy_q    <= 1'b1;
        lsu_own_q <= 1'b1;
      end else if (i_fetch_req.cyc) begin
        busy_q    <= 1'b1;
        lsu_own_q <= 1'b0;
      end
    end else if (i_wb.ack) begin
      busy_q <= 1'b0;  // the owner drops its request on the next cycle too
    end
  end

  always_comb begin
    o_wb = '0;
    if (busy_q) o_wb = lsu_own_q ? i_lsu_req : i_fetch_req;
    o_fetch_rsp.ack = busy_q && !lsu_own_q && i_wb.ack;  // the waiting master sees no ack
    o_fetch_rsp.dat = i_wb.dat;
    o_lsu_rsp.ack   = busy_q && lsu_own_q && i_wb.ack;
    o_lsu_rsp.dat   = i_wb.dat;
  end

endmodule

/* src/decoder.sv */
`timescale 1ns/1ns
module decoder (
  input  logic [hart_pkg::XLEN-1:0] i_inst,
  output hart_pkg::decoded_t        o_dec
);

  localparam logic [31:0] ebreak_word = 32'h0010_0073;

  hart_pkg::opcode_e         opc;
  hart_pkg::alu_op_e         alu_sel;
  logic [hart_pkg::XLEN-1:0] imm_i;
  logic [hart_pkg::XLEN-1:0] imm_s;
  logic [hart_pkg::XLEN-1:0] imm_b;
  logic [hart_pkg::XLEN-1:0] imm_u;
  logic [hart_pkg::XLEN-1:0] imm_j;

  assign opc = hart_pkg::opcode_e'(i_inst[6:0]);  // codes outside the enum fall to the default arm

  // immediates always sign extend from bit 31
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'b0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // funct3 picks the operation and funct7 bit 30 selects sub and sra
  always_comb begin
    case (i_inst[14:12])
      3'b000:  alu_sel = (opc == hart_pkg::opc_op && i_inst[30]) ? hart_pkg::alu_sub
                                                                 : hart_pkg::alu_add;
      3'b001:  alu_sel = hart_pkg::alu_sll;
      3'b010:  alu_sel = hart_pkg::alu_slt;
      3'b011:  alu_sel = hart_pkg::alu_sltu;
      3'b100:  alu_sel = hart_pkg::alu_xor;
      3'b101:  alu_sel = i_inst[30] ? hart_pkg::alu_sra : hart_pkg::alu_srl;
      3'b110:  alu_sel = hart_pkg::alu_or;
      default: alu_sel = hart_pkg::alu_and;
    endcase
  end

  always_comb begin
    o_dec         = '0;
    o_dec.opcode  = opc;
    o_dec.funct3  = i_inst[14:12];
    o_dec.alu_op  = hart_pkg::alu_add;  // address and target adds
    o_dec.rd      = i_inst[11:7];
    o_dec.rs1     = i_inst[19:15];
    o_dec.rs2     = i_inst[24:20];
    o_dec.is_halt = (i_inst == ebreak_word);
    case (opc)
      hart_pkg::opc_lui, hart_pkg::opc_auipc: begin
        o_dec.imm       = imm_u;
        o_dec.writes_rd = 1'b1;
      end
      hart_pkg::opc_jal: begin
        o_dec.imm       = imm_j;
        o_dec.writes_rd = 1'b1;
      end
      hart_pkg::opc_jalr, hart_pkg::opc_load: begin
        o_dec.imm       = imm_i;
        o_dec.uses_imm  = 1'b1;  // rs1 plus offset through the alu
        o_dec.writes_rd = 1'b1;
      end
      hart_pkg::opc_branch: o_dec.imm = imm_b;
      hart_pkg::opc_store: begin
        o_dec.imm      = imm_s;
        o_dec.uses_imm = 1'b1;
      end
      hart_pkg::opc_op_imm: begin
        o_dec.imm       = imm_i;
        o_dec.uses_imm  = 1'b1;
        o_dec.alu_op    = alu_sel;
        o_dec.writes_rd = 1'b1;
      end
      hart_pkg::opc_op: begin
        o_dec.alu_op    = alu_sel;
        o_dec.writes_rd = 1'b1;
      end
      default: o_dec.imm = imm_i;  // system and unknown words retire as no-ops
    endcase
  end

endmodule

/* src/hart_ctrl.sv */
`timescale 1ns/1ns
module hart_ctrl (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_inst_valid,
  input  logic [hart_pkg::XLEN-1:0] i_inst,
  input  logic [hart_pkg::XLEN-1:0] i_inst_pc,
  output logic                      o_take,
  output logic                      o_redirect,
  output logic [hart_pkg::XLEN-1:0] o_redirect_pc,
  output logic [hart_pkg::XLEN-1:0] o_inst_word,
  input  hart_pkg::decoded_t        i_dec,
  output logic [4:0]                o_rs1_addr,
  output logic [4:0]                o_rs2_addr,
  input  logic [hart_pkg::XLEN-1:0] i_rs1_data,
  input  logic [hart_pkg::XLEN-1:0] i_rs2_data,
  output logic                      o_rd_wen,
  output logic [4:0]                o_rd_waddr,
  output logic [hart_pkg::XLEN-1:0] o_rd_wdata,
  output logic                      o_ls_start,
  output logic                      o_ls_we,
  output logic [2:0]                o_ls_funct3,
  output logic [hart_pkg::XLEN-1:0] o_ls_addr,
  output logic [hart_pkg::XLEN-1:0] o_ls_wdata,
  input  logic                      i_ls_done,
  input  logic [hart_pkg::XLEN-1:0] i_ls_rdata,
  output hart_pkg::retire_t         o_retire
);

  typedef enum logic [1:0] {wait_inst, exec, mem_wait, halted} state_e;

  state_e                    state_q;
  logic                      mem_done_q;  // exec is revisited once the data cycle is over
  logic [hart_pkg::XLEN-1:0] inst_q;
  logic [hart_pkg::XLEN-1:0] pc_q;
  logic [hart_pkg::XLEN-1:0] ld_q;        // extended load data
  logic [hart_pkg::XLEN-1:0] op_b;
  logic [hart_pkg::XLEN-1:0] alu_res;
  logic [hart_pkg::XLEN-1:0] pc_imm;
  logic [hart_pkg::XLEN-1:0] pc_plus4;
  logic [hart_pkg::XLEN-1:0] target;
  logic [hart_pkg::XLEN-1:0] wb_data;
  logic                      br_cond;
  logic                      jump;
  logic                      is_mem;
  logic                      fin;         // the instruction retires this cycle

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q    <= wait_inst;
      mem_done_q <= 1'b0;
    end else begin
      case (state_q)
        wait_inst: if (i_inst_valid) state_q <= exec;
        exec: begin
          mem_done_q <= 1'b0;
          if (is_mem && !mem_done_q) state_q <= mem_wait;
          else if (i_dec.is_halt) state_q <= halted;  // ebreak parks the core for good
          else state_q <= wait_inst;
        end
        mem_wait: begin
          if (i_ls_done) begin
            state_q    <= exec;
            mem_done_q <= 1'b1;
          end
        end
        default: state_q <= halted;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_take) begin
      inst_q <= i_inst;
      pc_q   <= i_inst_pc;
    end
    if (i_ls_done) ld_q <= i_ls_rdata;
  end

  assign o_take      = (state_q == wait_inst) && i_inst_valid;
  assign o_inst_word = inst_q;
  assign o_rs1_addr  = i_dec.rs1;
  assign o_rs2_addr  = i_dec.rs2;

  always_comb begin
    op_b = i_dec.uses_imm ? i_dec.imm : i_rs2_data;
    case (i_dec.alu_op)
      hart_pkg::alu_sub:  alu_res = i_rs1_data - op_b;
      hart_pkg::alu_sll:  alu_res = i_rs1_data << op_b[4:0];
      hart_pkg::alu_slt:  alu_res = {31'b0, $signed(i_rs1_data) < $signed(op_b)};
      hart_pkg::alu_sltu: alu_res = {31'b0, i_rs1_data < op_b};
      hart_pkg::alu_xor:  alu_res = i_rs1_data ^ op_b;
      hart_pkg::alu_srl:  alu_res = i_rs1_data >> op_b[4:0];
      hart_pkg::alu_sra:  alu_res = $unsigned($signed(i_rs1_data) >>> op_b[4:0]);
      hart_pkg::alu_or:   alu_res = i_rs1_data | op_b;
      hart_pkg::alu_and:  alu_res = i_rs1_data & op_b;
      default:            alu_res = i_rs1_data + op_b;
    endcase
    case (i_dec.funct3)
      3'b000:  br_cond = i_rs1_data == i_rs2_data;
      3'b001:  br_cond = i_rs1_data != i_rs2_data;
      3'b100:  br_cond = $signed(i_rs1_data) < $signed(i_rs2_data);
      3'b101:  br_cond = $signed(i_rs1_data) >= $signed(i_rs2_data);
      3'b110:  br_cond = i_rs1_data < i_rs2_data;
      3'b111:  br_cond = i_rs1_data >= i_rs2_data;
      default: br_cond = 1'b0;
    endcase
  end

  assign pc_imm   = pc_q + i_dec.imm;
  assign pc_plus4 = pc_q + 32'd4;
  assign target   = (i_dec.opcode == hart_pkg::opc_jalr) ? alu_res : pc_imm;

  always_comb begin
    jump    = 1'b0;
    is_mem  = 1'b0;
    wb_data = alu_res;
    case (i_dec.opcode)
      hart_pkg::opc_lui:    wb_data = i_dec.imm;
      hart_pkg::opc_auipc:  wb_data = pc_imm;
      hart_pkg::opc_jal, hart_pkg::opc_jalr: begin
        jump    = 1'b1;
        wb_data = pc_plus4;  // link address
      end
      hart_pkg::opc_branch: jump = br_cond;
      hart_pkg::opc_load: begin
        is_mem  = 1'b1;
        wb_data = ld_q;
      end
      hart_pkg::opc_store:  is_mem = 1'b1;
      default:              jump = 1'b0;
    endcase
  end

  assign fin           = (state_q == exec) && (!is_mem || mem_done_q);
  assign o_redirect    = fin && jump;
  assign o_redirect_pc = {target[31:2], 2'b00};  // targets are aligned down to a word

  assign o_rd_wen   = fin && i_dec.writes_rd;
  assign o_rd_waddr = i_dec.rd;
  assign o_rd_wdata = wb_data;

  assign o_ls_start  = (state_q == exec) && is_mem && !mem_done_q;
  assign o_ls_we     = (i_dec.opcode == hart_pkg::opc_store);
  assign o_ls_funct3 = i_dec.funct3;
  assign o_ls_addr   = alu_res;
  assign o_ls_wdata  = i_rs2_data;

  always_comb begin
    o_retire.valid    = fin;
    o_retire.halt     = i_dec.is_halt;
    o_retire.pc       = pc_q;
    o_retire.next_pc  = jump ? o_redirect_pc : pc_plus4;
    o_retire.inst     = inst_q;
    o_retire.rd_waddr = i_dec.writes_rd ? i_dec.rd : 5'd0;
    o_retire.rd_wdata = i_dec.writes_rd ? wb_data : '0;
  end

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ns
module reg_file (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic [4:0]                i_rs1_addr,
  input  logic [4:0]                i_rs2_addr,
  output logic [hart_pkg::XLEN-1:0] o_rs1_data,
  output logic [hart_pkg::XLEN-1:0] o_rs2_data,
  input  logic                      i_wen,
  input  logic [4:0]                i_waddr,
  input  logic [hart_pkg::XLEN-1:0] i_wdata
);

  logic [hart_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != 5'd0)) begin
      regs[i_waddr] <= i_wdata;  // writes to x0 are dropped
    end
  end

  // reads are combinational so exec sees the operands in the same cycle
  assign o_rs1_data = (i_rs1_addr == 5'd0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == 5'd0) ? '0 : regs[i_rs2_addr];

endmodule

/* src/load_store_unit.sv */
`timescale 1ns/1ns
module load_store_unit (
  input  logic                      i_clk,
  input  logic                      i_rst,
  input  logic                      i_start,
  input  logic                      i_we,
  input  logic [2:0]                i_funct3,  // size in bits 1:0 and unsigned load in bit 2
  input  logic [hart_pkg::XLEN-1:0] i_addr,
  input  logic [hart_pkg::XLEN-1:0] i_wdata,
  output logic                      o_done,
  output logic [hart_pkg::XLEN-1:0] o_rdata,
  output hart_pkg::wb_req_t         o_bus,
  input  hart_pkg::wb_rsp_t         i_bus
);

  logic                      req_q;
  logic                      we_q;
  logic [2:0]                funct3_q;
  logic [1:0]                off_q;
  logic [3:0]                sel_q;
  logic [hart_pkg::XLEN-1:0] adr_q;
  logic [hart_pkg::XLEN-1:0] dat_q;
  logic [1:0]                off;
  logic [3:0]                sel;
  logic [hart_pkg::XLEN-1:0] lane;

  // the byte offset is aligned down to the access size
  always_comb begin
    case (i_funct3[1:0])
      2'b00: begin
        off = i_addr[1:0];
        sel = 4'b0001 << i_addr[1:0];
      end
      2'b01: begin
        off = {i_addr[1], 1'b0};
        sel = 4'b0011 << {i_addr[1], 1'b0};
      end
      default: begin
        off = 2'b00;
        sel = 4'b1111;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) req_q <= 1'b0;
    else if (i_start) req_q <= 1'b1;
    else if (i_bus.ack) req_q <= 1'b0;  // the arbiter only acks the owner
  end

  always_ff @(posedge i_clk) begin
    if (i_start) begin
      we_q     <= i_we;
      funct3_q <= i_funct3;
      off_q    <= off;
      sel_q    <= sel;
      adr_q    <= {i_addr[31:2], 2'b00};
      dat_q    <= i_wdata << {off, 3'b000};  // store data moves into its lane
    end
  end

  always_comb begin
    o_bus     = '0;
    o_bus.cyc = req_q;
    o_bus.stb = req_q;
    o_bus.we  = we_q;
    o_bus.adr = adr_q;
    o_bus.dat = dat_q;
    o_bus.sel = sel_q;
  end

  // load data comes back down to bit 0 and is then extended
  assign lane   = i_bus.dat >> {off_q, 3'b000};
  assign o_done = req_q && i_bus.ack;

  always_comb begin
    case (funct3_q)
      3'b000:  o_rdata = {{24{lane[7]}}, lane[7:0]};
      3'b001:  o_rdata = {{16{lane[15]}}, lane[15:0]};
      3'b100:  o_rdata = {24'b0, lane[7:0]};
      3'b101:  o_rdata = {16'b0, lane[15:0]};
      default: o_rdata = lane;
    endcase
  end

endmodule

/* src/hart_top.sv */
`timescale 1ns/1ns
module hart_top #(
  parameter logic [hart_pkg::XLEN-1:0] RESET_ADDR = 32'h0000_0000  // first fetch address
) (
  input  logic              i_clk,
  input  logic              i_rst,
  output hart_pkg::wb_req_t o_wb,
  input  hart_pkg::wb_rsp_t i_wb,
  output hart_pkg::retire_t o_retire
);

  hart_pkg::wb_req_t           fetch_req;
  hart_pkg::wb_rsp_t           fetch_rsp;
  hart_pkg::wb_req_t           lsu_req;
  hart_pkg::wb_rsp_t           lsu_rsp;
  logic                        inst_valid;
  logic [hart_pkg::XLEN-1:0]   inst;
  logic [hart_pkg::XLEN-1:0]   inst_pc;
  logic                        take;
  logic                        redirect;
  logic [hart_pkg::XLEN-1:0]   redirect_pc;
  logic [hart_pkg::XLEN-1:0]   inst_word;
  hart_pkg::decoded_t          dec;
  logic [4:0]                  rs1_addr;
  logic [4:0]                  rs2_addr;
  logic [hart_pkg::XLEN-1:0]   rs1_data;
  logic [hart_pkg::XLEN-1:0]   rs2_data;
  logic                        rd_wen;
  logic [4:0]                  rd_waddr;
  logic [hart_pkg::XLEN-1:0]   rd_wdata;
  logic                        ls_start;
  logic                        ls_we;
  logic [2:0]                  ls_funct3;
  logic [hart_pkg::XLEN-1:0]   ls_addr;
  logic [hart_pkg::XLEN-1:0]   ls_wdata;
  logic                        ls_done;
  logic [hart_pkg::XLEN-1:0]   ls_rdata;

  fetch_unit #(.RESET_ADDR(RESET_ADDR)) u_fetch (
    .i_clk, .i_rst, .i_take(take), .i_redirect(redirect), .i_redirect_pc(redirect_pc),
    .o_inst_valid(inst_valid), .o_inst(inst), .o_inst_pc(inst_pc),
    .o_bus(fetch_req), .i_bus(fetch_rsp)
  );

  // data accesses win the single wishbone port
  bus_arbiter u_arb (
    .i_clk, .i_rst, .i_fetch_req(fetch_req), .o_fetch_rsp(fetch_rsp),
    .i_lsu_req(lsu_req), .o_lsu_rsp(lsu_rsp), .o_wb, .i_wb
  );

  decoder u_dec (.i_inst(inst_word), .o_dec(dec));

  hart_ctrl u_ctrl (
    .i_clk, .i_rst,
    .i_inst_valid(inst_valid), .i_inst(inst), .i_inst_pc(inst_pc),
    .o_take(take), .o_redirect(redirect), .o_redirect_pc(redirect_pc),
    .o_inst_word(inst_word), .i_dec(dec),
    .o_rs1_addr(rs1_addr), .o_rs2_addr(rs2_addr), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data),
    .o_rd_wen(rd_wen), .o_rd_waddr(rd_waddr), .o_rd_wdata(rd_wdata),
    .o_ls_start(ls_start), .o_ls_we(ls_we), .o_ls_funct3(ls_funct3),
    .o_ls_addr(ls_addr), .o_ls_wdata(ls_wdata), .i_ls_done(ls_done), .i_ls_rdata(ls_rdata),
    .o_retire
  );

  reg_file u_rf (
    .i_clk, .i_rst, .i_rs1_addr(rs1_addr), .i_rs2_addr(rs2_addr),
    .o_rs1_data(rs1_data), .o_rs2_data(rs2_data),
    .i_wen(rd_wen), .i_waddr(rd_waddr), .i_wdata(rd_wdata)
  );

  load_store_unit u_lsu (
    .i_clk, .i_rst, .i_start(ls_start), .i_we(ls_we), .i_funct3(ls_funct3),
    .i_addr(ls_addr), .i_wdata(ls_wdata), .o_done(ls_done), .o_rdata(ls_rdata),
    .o_bus(lsu_req), .i_bus(lsu_rsp)
  );

endmodule

/* testbench/hart_checker.sv */
`timescale 1ns/1ns
module hart_checker (
  input logic              i_clk,
  input logic              i_rst,
  input hart_pkg::wb_req_t i_req,     // the shared wishbone request
  input hart_pkg::wb_rsp_t i_rsp,
  input hart_pkg::retire_t i_retire
);

  logic halted_q;  // set once ebreak has retired

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      halted_q <= 1'b0;
    end else if (i_retire.valid && i_retire.halt) begin
      halted_q <= 1'b1;
    end
  end

  // the port comes out of reset idle and with nothing retiring
  reset_idle: assert property (@(posedge i_clk)
    i_rst |=> !i_req.cyc && !i_req.stb && !i_retire.valid)
    else $error("bus or retire port active right after reset");

  stb_in_cyc: assert property (@(posedge i_clk) disable iff (i_rst)
    i_req.stb |-> i_req.cyc)
    else $error("stb raised outside a bus cycle");

  // a classic slave may stretch the cycle, the master must hold everything until ack
  req_held: assert property (@(posedge i_clk) disable iff (i_rst)
    i_req.stb && !i_rsp.ack |=> i_req.stb && $stable(i_req.adr) && $stable(i_req.we)
                               && $stable(i_req.dat) && $stable(i_req.sel))
    else $error("request changed or dropped before ack");

  retire_single: assert property (@(posedge i_clk) disable iff (i_rst)
    i_retire.valid |=> !i_retire.valid)
    else $error("retire valid high on two cycles in a row");

  quiet_after_halt: assert property (@(posedge i_clk) disable iff (i_rst)
    halted_q |-> !i_retire.valid)
    else $error("instruction retired after ebreak");

endmodule

/* testbench/tb_hart.sv */
`timescale 1ns/1ns
module tb_hart;

  localparam logic [31:0] reset_addr     = 32'h0000_0100;
  localparam int          retire_timeout = 200;  // cycles allowed per instruction including ack stalls
  localparam int          quiet_cycles   = 60;

  // major opcodes for building the program image
  localparam int opc_lui    = 'h37;
  localparam int opc_auipc  = 'h17;
  localparam int opc_jalr   = 'h67;
  localparam int opc_load   = 'h03;
  localparam int opc_op_imm = 'h13;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;    // zero when no register is written
    logic [31:0] data;
    logic        halt;
  } step_t;

  logic              clk = 1'b0;
  logic              rst = 1'b1;
  hart_pkg::wb_req_t wb_req;
  hart_pkg::wb_rsp_t wb_rsp = '0;
  hart_pkg::retire_t retire;
  logic [31:0]       mem [256];      // 1 KiB unified memory
  logic [15:0]       lfsr_q = 16'd11;
  logic [3:0]        sel_expect [$];  // byte selects of the stores in program order
  step_t             steps [$];

  hart_top #(.RESET_ADDR(reset_addr)) dut0 (
    .i_clk(clk), .i_rst(rst), .o_wb(wb_req), .i_wb(wb_rsp), .o_retire(retire)
  );

  bind hart_top hart_checker u_checker (
    .i_clk(i_clk), .i_rst(i_rst), .i_req(o_wb), .i_rsp(i_wb), .i_retire(o_retire)
  );

  always #20 clk = ~clk;

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_problem(input string why);
    $display("%s", why);
    abort_run();
  endtask

  task automatic report_mismatch(input string test, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("ERROR %s expected %h actual %h", test, expected, actual);
    abort_run();
  endtask

  // fibonacci taps at bits 16 14 13 and 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_delay(output int d);
    logic b0;
    logic b1;
    lfsr_q = lfsr_step(lfsr_q);
    b0 = lfsr_q[0];
    lfsr_q = lfsr_step(lfsr_q);
    b1 = lfsr_q[0];
    d = {30'b0, b1, b0};  // 0 to 3 wait cycles
  endtask

  function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                         input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                         input int rd, input int opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                         input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] u_type(input int imm20, input int rd, input int opc);
    return {imm20[19:0], rd[4:0], opc[6:0]};
  endfunction

  function automatic logic [31:0] j_type(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  task automatic place(input int addr, input logic [31:0] word);
    mem[addr[9:2]] = word;
  endtask

  task automatic load_program();
    for (int i = 0; i < 256; i++) begin
      mem[i] = {16'hfee0, 6'b0, i[7:0], 2'b00};  // the filler carries its own byte address
    end
    place('h100, u_type('h12345, 1, opc_lui));
    place('h104, u_type('h1, 2, opc_auipc));
    place('h108, i_type(-5, 0, 0, 3, opc_op_imm));
    place('h10c, i_type(7, 0, 0, 4, opc_op_imm));
    place('h110, r_type(0, 4, 3, 0, 5));          // add x5, x3, x4
    place('h114, r_type('h20, 3, 4, 0, 6));       // sub x6, x4, x3
    place('h118, r_type(0, 4, 3, 4, 7));          // xor x7, x3, x4
    place('h11c, r_type(0, 4, 3, 2, 8));          // slt x8, x3, x4
    place('h120, r_type(0, 4, 4, 1, 9));          // sll x9, x4, x4
    place('h124, r_type('h20, 5, 3, 5, 10));      // sra x10, x3, x5
    place('h128, i_type(1, 4, 0, 0, opc_op_imm)); // result dropped into x0
    place('h12c, i_type('h200, 0, 0, 11, opc_op_imm));
    place('h130, u_type('h89abd, 12, opc_lui));
    place('h134, i_type(-'h322, 12, 0, 12, opc_op_imm));
    place('h138, s_type(0, 12, 11, 2));           // sw
    place('h13c, s_type(2, 4, 11, 1));           // sh into the upper half
    place('h140, s_type(1, 3, 11, 0));           // sb at offsets 1, 3 and 0
    place('h144, s_type(3, 6, 11, 0));
    place('h148, s_type(0, 5, 11, 0));
    place('h14c, i_type(0, 11, 2, 13, opc_load)); // lw
    place('h150, i_type(0, 11, 1, 14, opc_load)); // lh
    place('h154, i_type(0, 11, 5, 15, opc_load)); // lhu
    place('h158, i_type(1, 11, 0, 16, opc_load)); // lb
    place('h15c, i_type(1, 11, 4, 17, opc_load)); // lbu
    place('h160, i_type(2, 11, 1, 18, opc_load)); // lh from the upper half
    place('h164, b_type(8, 5, 5, 0));             // beq taken over the next word
    place('h168, i_type(1, 0, 0, 19, opc_op_imm));
    place('h16c, b_type(8, 5, 5, 1));             // bne falls through
    place('h170, j_type(12, 20));
    place('h174, i_type(1, 0, 0, 21, opc_op_imm));
    place('h178, i_type(2, 0, 0, 21, opc_op_imm));
    place('h17c, i_type('h190, 0, 0, 22, opc_op_imm));
    place('h180, i_type(4, 22, 0, 23, opc_jalr));
    place('h194, 32'h0010_0073);                  // ebreak
  endtask

  task automatic add_step(input logic [31:0] pc, input int rd, input logic [31:0] data,
                          input logic halt);
    step_t s;
    s.pc   = pc;
    s.rd   = rd[4:0];
    s.data = data;
    s.halt = halt;
    steps.push_back(s);
  endtask

  // expected retires worked out by hand from the rv32i rules
  task automatic build_table();
    add_step(32'h100, 1, 32'h1234_5000, 1'b0);
    add_step(32'h104, 2, 32'h0000_1104, 1'b0);
    add_step(32'h108, 3, 32'hffff_fffb, 1'b0);
    add_step(32'h10c, 4, 32'h0000_0007, 1'b0);
    add_step(32'h110, 5, 32'h0000_0002, 1'b0);
    add_step(32'h114, 6, 32'h0000_000c, 1'b0);
    add_step(32'h118, 7, 32'hffff_fffc, 1'b0);
    add_step(32'h11c, 8, 32'h0000_0001, 1'b0);
    add_step(32'h120, 9, 32'h0000_0380, 1'b0);
    add_step(32'h124, 10, 32'hffff_fffe, 1'b0);
    add_step(32'h128, 0, 32'h0, 1'b0);
    add_step(32'h12c, 11, 32'h0000_0200, 1'b0);
    add_step(32'h130, 12, 32'h89ab_d000, 1'b0);
    add_step(32'h134, 12, 32'h89ab_ccde, 1'b0);
    for (int a = 'h138; a <= 'h148; a += 4) begin
      add_step(a, 0, 32'h0, 1'b0);  // stores write no register
    end
    add_step(32'h14c, 13, 32'h0c07_fb02, 1'b0);  // word left by the five stores
    add_step(32'h150, 14, 32'hffff_fb02, 1'b0);
    add_step(32'h154, 15, 32'h0000_fb02, 1'b0);
    add_step(32'h158, 16, 32'hffff_fffb, 1'b0);
    add_step(32'h15c, 17, 32'h0000_00fb, 1'b0);
    add_step(32'h160, 18, 32'h0000_0c07, 1'b0);
    add_step(32'h164, 0, 32'h0, 1'b0);
    add_step(32'h16c, 0, 32'h0, 1'b0);
    add_step(32'h170, 20, 32'h0000_0174, 1'b0);
    add_step(32'h17c, 22, 32'h0000_0190, 1'b0);
    add_step(32'h180, 23, 32'h0000_0184, 1'b0);
    add_step(32'h194, 0, 32'h0, 1'b1);
  endtask

  // wishbone slave that answers 1 ns after the edge with a random number of wait cycles
  initial begin : memory_model
    int          delay;
    logic        pending;
    logic [7:0]  idx;
    logic [3:0]  exp_sel;
    pending = 1'b0;
    delay   = 0;
    load_program();
    sel_expect = '{4'b1111, 4'b1100, 4'b0010, 4'b1000, 4'b0001};
    forever begin
      @(posedge clk);
      #1;
      if (wb_rsp.ack) begin
        wb_rsp.ack = 1'b0;  // master releases the cycle after its ack
        pending    = 1'b0;
      end else if (wb_req.cyc === 1'b1 && wb_req.stb === 1'b1) begin
        if (!pending) begin
          pending = 1'b1;
          draw_delay(delay);
        end
        if (delay == 0) begin
          assert (wb_req.adr < 32'h400) else report_problem("bus address outside the memory");
          idx = wb_req.adr[9:2];
          if (wb_req.we) begin
            assert (sel_expect.size() != 0)
              else report_problem("a store reached the bus that the program does not hold");
            exp_sel = sel_expect.pop_front();
            assert (wb_req.sel == exp_sel)
              else report_mismatch("store byte select", {28'b0, exp_sel}, {28'b0, wb_req.sel});
            for (int b = 0; b < 4; b++) begin
              if (wb_req.sel[b]) mem[idx][8*b +: 8] = wb_req.dat[8*b +: 8];
            end
          end else begin
            wb_rsp.dat = mem[idx];
          end
          wb_rsp.ack = 1'b1;
        end else begin
          delay--;
        end
      end
    end
  end

  // retire outputs settle well before the falling edge
  task automatic wait_retire(output hart_pkg::retire_t r);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!retire.valid) begin
      assert (cycles < retire_timeout)
        else report_problem($sformatf("no instruction retired within %0d cycles", retire_timeout));
      cycles++;
      @(negedge clk);
    end
    r = retire;
  endtask

  task automatic check_retire(input int i, input step_t s, input hart_pkg::retire_t r,
                              input logic [31:0] prev_next);
    assert (r.pc == s.pc) else report_mismatch($sformatf("step %0d pc", i), s.pc, r.pc);
    assert (r.pc == prev_next)
      else report_mismatch($sformatf("step %0d pc against next_pc", i), prev_next, r.pc);
    assert (r.inst == mem[s.pc[9:2]])
      else report_mismatch($sformatf("step %0d inst", i), mem[s.pc[9:2]], r.inst);
    assert (r.rd_waddr == s.rd)
      else report_mismatch($sformatf("step %0d rd", i), {27'b0, s.rd}, {27'b0, r.rd_waddr});
    if (s.rd != 5'd0) begin  // a write to x0 leaves no value to compare
      assert (r.rd_wdata == s.data)
        else report_mismatch($sformatf("step %0d rd data", i), s.data, r.rd_wdata);
    end
    assert (r.halt == s.halt)
      else report_mismatch($sformatf("step %0d halt", i), {31'b0, s.halt}, {31'b0, r.halt});
  endtask

  initial begin : run
    hart_pkg::retire_t r;
    logic [31:0]       prev_next;
    build_table();
    repeat (5) @(posedge clk);
    #1;
    rst       = 1'b0;
    prev_next = reset_addr;  // the first retire comes from the reset address
    for (int i = 0; i < steps.size(); i++) begin
      wait_retire(r);
      check_retire(i, steps[i], r, prev_next);
      prev_next = r.next_pc;
    end
    for (int c = 0; c < quiet_cycles; c++) begin
      @(negedge clk);
      assert (!retire.valid) else report_problem("an instruction retired after ebreak");
    end
    assert (sel_expect.size() == 0) else report_problem("not every store reached the bus");
    $display(">>> PASS");
    $finish;
  end

endmodule

/* all.f */
src/hart_pkg.sv
src/fetch_unit.sv
src/bus_arbiter.sv
src/decoder.sv
src/hart_ctrl.sv
src/reg_file.sv
src/load_store_unit.sv
src/hart_top.sv
testbench/hart_checker.sv
testbench/tb_hart.sv

/* Makefile */
# Verilator build and run of the hart testbench
# the run exits with a non-zero status when the testbench stops on a failure

TOP     ?= tb_hart
FLIST   ?= all.f
OBJDIR  ?= obj_dir
VFLAGS  ?= -j 0
VERILATOR ?= verilator

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert $(VFLAGS) --top-module $(TOP) \
		-Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
